//--- Makefile
VERILATOR ?= verilator
TOP       ?= kitchenVerifierTb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- all.f
design/kitchenPkg.sv
design/recipePkg.sv
design/stationIf.sv
design/operationChecker.sv
design/stationSlot.sv
design/outcomeStage.sv
design/kitchenVerifier.sv
dv/tbClock.sv
dv/kitchenVerifierTb.sv

//--- design/kitchenPkg.sv
package kitchenPkg;

    typedef enum logic [2:0] {
        opIgnore   = 3'd0,
        opGet      = 3'd1,
        opPut      = 3'd2,
        opThrow    = 3'd3,
        opInteract = 3'd4
    } opCode_e;

    // machine number sits in bits 6:2 of the target byte
    typedef logic [4:0] machineId_t;

    localparam machineId_t crateFirst     = 5'd1;
    localparam machineId_t crateLast      = 5'd6;
    localparam machineId_t stoneMill      = 5'd7;
    localparam machineId_t cuttingMachine = 5'd8;
    localparam machineId_t ovenLow        = 5'd12;
    localparam machineId_t ovenHigh       = 5'd13;
    localparam machineId_t customer       = 5'd18;
    localparam machineId_t trashBin       = 5'd20;

    localparam int numSlots = 9;

    // tables first, then the two processors, then the ovens
    localparam machineId_t slotMachine [numSlots] = '{
        5'd9, 5'd11, 5'd14, 5'd17, 5'd19,
        stoneMill, cuttingMachine,
        ovenLow, ovenHigh
    };

    typedef enum logic [1:0] {
        kindTable     = 2'd0,
        kindProcessor = 2'd1,
        kindOven      = 2'd2
    } slotKind_e;

    function automatic slotKind_e slotKindOf(input int unsigned idx);
        slotKind_e kind;
        case (slotMachine[idx])
            stoneMill, cuttingMachine: kind = kindProcessor;
            ovenLow, ovenHigh:         kind = kindOven;
            default:                   kind = kindTable;
        endcase
        return kind;
    endfunction

endpackage

//--- design/kitchenVerifier.sv
`timescale 1ns/1ps

module kitchenVerifier #(
    parameter int stackDepth = 3,
    parameter int countWidth = 3
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  opValid,
    input  kitchenPkg::opCode_e   opCode,
    input  logic [7:0]            targetMachine,
    input  logic                  inFront,
    output logic                  verifiedValid,
    output kitchenPkg::opCode_e   verifiedOp,
    output logic [countWidth-1:0] dishCount
);
    import kitchenPkg::*;
    import recipePkg::*;

    localparam int countW = $clog2(stackDepth + 1);

    logic [numSlots-1:0] slotSel;
    logic                decisionValid;
    opCode_e             decisionOp;
    logic                delivered;
    logic [countW-1:0]   selCount;
    item_e               selTop;

    stationIf #(.stackDepth(stackDepth)) slotBus [numSlots] ();

    operationChecker #(
        .stackDepth(stackDepth)
    ) checker_i (
        .clk           (clk),
        .rstN          (rstN),
        .opValid       (opValid),
        .opCode        (opCode),
        .targetMachine (targetMachine),
        .inFront       (inFront),
        .selCount      (selCount),
        .selTop        (selTop),
        .slotSel       (slotSel),
        .decisionValid (decisionValid),
        .decisionOp    (decisionOp),
        .delivered     (delivered),
        .slots         (slotBus)
    );

    genvar g;
    generate
        for (g = 0; g < numSlots; g++) begin : genSlot
            stationSlot #(
                .slotIndex  (g),
                .stackDepth (stackDepth)
            ) slot_i (
                .clk  (clk),
                .rstN (rstN),
                .slot (slotBus[g])
            );
        end
    endgenerate

    outcomeStage #(
        .stackDepth (stackDepth),
        .countWidth (countWidth)
    ) outcome_i (
        .clk           (clk),
        .rstN          (rstN),
        .slotSel       (slotSel),
        .decisionValid (decisionValid),
        .decisionOp    (decisionOp),
        .delivered     (delivered),
        .selCount      (selCount),
        .selTop        (selTop),
        .verifiedValid (verifiedValid),
        .verifiedOp    (verifiedOp),
        .dishCount     (dishCount),
        .slots         (slotBus)
    );

endmodule

//--- design/operationChecker.sv
`timescale 1ns/1ps

module operationChecker #(
    parameter int stackDepth = 3
) (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               opValid,
    input  kitchenPkg::opCode_e                opCode,
    input  logic [7:0]                         targetMachine,
    input  logic                               inFront,
    input  logic [$clog2(stackDepth+1)-1:0]    selCount,
    input  recipePkg::item_e                   selTop,
    output logic [kitchenPkg::numSlots-1:0]    slotSel,
    output logic                               decisionValid,
    output kitchenPkg::opCode_e                decisionOp,
    output logic                               delivered,
    stationIf.issuer                           slots [kitchenPkg::numSlots]
);
    import kitchenPkg::*;
    import recipePkg::*;

    localparam int countW = $clog2(stackDepth + 1);
    localparam logic [countW-1:0] fullCount = countW'(stackDepth);

    machineId_t machine;
    item_e      hand;
    item_e      nextHand;
    logic       handFull;
    logic       isCrate;
    logic       slotHit;
    slotKind_e  selKind;
    logic       legal;
    logic       issue;

    assign machine  = targetMachine[6:2];
    assign handFull = (hand != itemNone);
    assign isCrate  = (machine >= crateFirst) && (machine <= crateLast);

    genvar g;
    generate
        for (g = 0; g < numSlots; g++) begin : genSel
            assign slotSel[g] = (machine == slotMachine[g]);
            assign slots[g].cmdValid = issue && slotSel[g];
            assign slots[g].cmdOp    = opCode;
            assign slots[g].cmdItem  = hand;
        end
    endgenerate

    always_comb begin
        slotHit = 1'b0;
        selKind = kindTable;
        for (int i = 0; i < numSlots; i++) begin
            if (slotSel[i]) begin
                slotHit = 1'b1;
                selKind = slotKindOf(i);
            end
        end
    end

    always_comb begin
        legal     = 1'b0;
        delivered = 1'b0;
        nextHand  = hand;
        if (opValid && inFront) begin
            if (isCrate) begin
                if (opCode == opGet && !handFull) begin
                    legal    = 1'b1;
                    nextHand = item_e'(machine);
                end
            end else if (slotHit) begin
                case (opCode)
                    opGet: begin
                        legal    = !handFull && (selCount != '0);
                        nextHand = legal ? selTop : hand;
                    end
                    opPut, opThrow: begin
                        // processors take one item, tables and ovens fill up to depth
                        if (selKind == kindProcessor) begin
                            legal = handFull && opCode == opPut && selCount == '0;
                        end else if (selKind == kindOven) begin
                            legal = handFull && opCode == opPut && selCount < fullCount;
                        end else begin
                            legal = handFull && selCount < fullCount;
                        end
                        nextHand = legal ? itemNone : hand;
                    end
                    opInteract: legal = 1'b1;
                    default:    legal = 1'b0;
                endcase
            end else if (machine == trashBin) begin
                if ((opCode == opPut || opCode == opThrow) && handFull) begin
                    legal    = 1'b1;
                    nextHand = itemNone;
                end
            end else if (machine == customer) begin
                if (opCode == opPut && isDish(hand)) begin
                    legal     = 1'b1;
                    delivered = 1'b1;
                    nextHand  = itemNone;
                end
            end
        end
    end

    // an empty table has nothing to act on
    assign issue = legal && slotHit &&
                   !(selKind == kindTable && opCode == opInteract && selCount == '0);

    assign decisionValid = opValid;
    assign decisionOp    = legal ? opCode : opIgnore;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hand <= itemNone;
        end else begin
            hand <= nextHand;
        end
    end

endmodule

//--- design/outcomeStage.sv
`timescale 1ns/1ps

module outcomeStage #(
    parameter int stackDepth = 3,
    parameter int countWidth = 3
) (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic [kitchenPkg::numSlots-1:0]    slotSel,
    input  logic                               decisionValid,
    input  kitchenPkg::opCode_e                decisionOp,
    input  logic                               delivered,
    output logic [$clog2(stackDepth+1)-1:0]    selCount,
    output recipePkg::item_e                   selTop,
    output logic                               verifiedValid,
    output kitchenPkg::opCode_e                verifiedOp,
    output logic [countWidth-1:0]              dishCount,
    stationIf.monitor                          slots [kitchenPkg::numSlots]
);
    import kitchenPkg::*;
    import recipePkg::*;

    localparam int countW = $clog2(stackDepth + 1);

    logic [countW-1:0] slotCount [numSlots];
    item_e             slotTop   [numSlots];

    genvar g;
    generate
        for (g = 0; g < numSlots; g++) begin : genRead
            assign slotCount[g] = slots[g].count;
            assign slotTop[g]   = slots[g].topItem;
        end
    endgenerate

    // readback for the checker in the same cycle
    always_comb begin
        selCount = '0;
        selTop   = itemNone;
        for (int i = 0; i < numSlots; i++) begin
            if (slotSel[i]) begin
                selCount = slotCount[i];
                selTop   = slotTop[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            verifiedValid <= 1'b0;
            verifiedOp    <= opIgnore;
            dishCount     <= '0;
        end else begin
            verifiedValid <= decisionValid;
            verifiedOp    <= decisionOp;
            // wraps on overflow
            dishCount     <= dishCount + countWidth'(delivered);
        end
    end

    slotSelOneHot: assert property (@(posedge clk) disable iff (!rstN)
        $onehot0(slotSel));

endmodule

//--- design/recipePkg.sv
package recipePkg;

    // raw ingredients share their number with the crate that gives them
    typedef enum logic [4:0] {
        itemNone        = 5'd0,
        rawMeat         = 5'd1,
        wheat           = 5'd2,
        sweetFlower     = 5'd3,
        jueyunChili     = 5'd4,
        berry           = 5'd5,
        salt            = 5'd6,
        slicedMeat      = 5'd7,
        flour           = 5'd8,
        sugar           = 5'd9,
        spice           = 5'd10,
        sausage         = 5'd11,
        sweetMadame     = 5'd12,
        chiliChicken    = 5'd13,
        berryMissManjuu = 5'd14,
        badDish         = 5'd15
    } item_e;

    function automatic logic isDish(input item_e it);
        return it inside {[sweetMadame:badDish]};
    endfunction

    function automatic item_e processItem(input item_e it);
        item_e result;
        case (it)
            rawMeat:     result = slicedMeat;
            wheat:       result = flour;
            sweetFlower: result = sugar;
            jueyunChili: result = spice;
            slicedMeat:  result = sausage;
            default:     result = it;
        endcase
        return result;
    endfunction

    function automatic logic holds(input item_e a, input item_e b, input item_e c,
                                   input item_e x);
        return (a == x) || (b == x) || (c == x);
    endfunction

    // itemNone back means no recipe applies and the oven keeps its contents
    function automatic item_e cookStack(input item_e a, input item_e b, input item_e c,
                                        input int unsigned n);
        item_e result;
        result = itemNone;
        if (n == 2 && ((a == rawMeat && b == sweetFlower) ||
                       (a == sweetFlower && b == rawMeat))) begin
            result = sweetMadame;
        end else if (n == 3 && holds(a, b, c, spice) && holds(a, b, c, rawMeat) &&
                     holds(a, b, c, jueyunChili)) begin
            result = chiliChicken;
        end else if (n == 3 && holds(a, b, c, sugar) && holds(a, b, c, berry) &&
                     holds(a, b, c, flour)) begin
            result = berryMissManjuu;
        end else if (n == 1 && isDish(a)) begin
            // recooking any dish burns it
            result = badDish;
        end
        return result;
    endfunction

endpackage

//--- design/stationIf.sv
`timescale 1ns/1ps

interface stationIf #(
    parameter int stackDepth = 3
);
    import kitchenPkg::*;
    import recipePkg::*;

    localparam int countW = $clog2(stackDepth + 1);

    logic              cmdValid;
    opCode_e           cmdOp;
    item_e             cmdItem;
    logic [countW-1:0] count;
    item_e             topItem;

    modport issuer (output cmdValid, output cmdOp, output cmdItem);
    modport station (input cmdValid, input cmdOp, input cmdItem,
                     output count, output topItem);
    modport monitor (input count, input topItem);

endinterface

//--- design/stationSlot.sv
`timescale 1ns/1ps

module stationSlot #(
    parameter int slotIndex  = 0,
    parameter int stackDepth = 3
) (
    input  logic       clk,
    input  logic       rstN,
    stationIf.station  slot
);
    import kitchenPkg::*;
    import recipePkg::*;

    localparam int        countW = $clog2(stackDepth + 1);
    localparam slotKind_e kind   = slotKindOf(slotIndex);

    item_e             items [stackDepth];
    logic [countW-1:0] count;
    item_e             cooked;
    logic              isPush;
    logic              isPop;
    logic              isInteract;

    assign isPush     = slot.cmdValid && (slot.cmdOp == opPut || slot.cmdOp == opThrow);
    assign isPop      = slot.cmdValid && slot.cmdOp == opGet;
    assign isInteract = slot.cmdValid && slot.cmdOp == opInteract;

    // bottom of the stack is items[0]
    assign cooked = cookStack(items[0], items[1], items[2], 32'(count));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
        end else if (isPush) begin
            count <= count + 1'b1;
        end else if (isPop) begin
            count <= count - 1'b1;
        end else if (isInteract && kind == kindOven && cooked != itemNone) begin
            count <= countW'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (isPush) begin
            items[count] <= slot.cmdItem;
        end else if (isInteract && kind == kindProcessor && count != '0) begin
            items[0] <= processItem(items[0]);
        end else if (isInteract && kind == kindOven && cooked != itemNone) begin
            items[0] <= cooked;
        end
    end

    assign slot.count   = count;
    assign slot.topItem = (count == '0) ? itemNone : items[count - 1'b1];

    noPushWhenFull: assert property (@(posedge clk) disable iff (!rstN)
        isPush |-> count < countW'(stackDepth));

    noPopWhenEmpty: assert property (@(posedge clk) disable iff (!rstN)
        isPop |-> count != '0);

    noEmptyTableInteract: assert property (@(posedge clk) disable iff (!rstN)
        (isInteract && kind == kindTable) |-> count != '0);

endmodule

//--- dv/kitchenVerifierTb.sv
`timescale 1ns/1ps

module kitchenVerifierTb;
    import kitchenPkg::*;
    import recipePkg::*;

    localparam int stackDepth    = 3;
    localparam int countWidth    = 3;
    localparam int maxCycles     = 700;
    localparam int numModelSlots = 9;

    logic                  clk;
    logic                  rstN;
    logic                  opValid;
    opCode_e               opCode;
    logic [7:0]            targetMachine;
    logic                  inFront;
    logic                  verifiedValid;
    opCode_e               verifiedOp;
    logic [countWidth-1:0] dishCount;

    // reference model of the hand, the slot stacks and the delivered dishes
    item_e mHand;
    item_e mItems [numModelSlots][stackDepth];
    int    mCount [numModelSlots];
    int    mDishes;

    opCode_e               expOps    [$];
    logic [countWidth-1:0] expCounts [$];
    logic                  strobeSeen;
    int                    cycleCount = 0;
    int                    seed;

    tbClock #(.periodNs(100), .resetCycles(10)) clock_i (.clk(clk), .rstN(rstN));

    kitchenVerifier #(
        .stackDepth (stackDepth),
        .countWidth (countWidth)
    ) kitchenVerifier_i (
        .clk           (clk),
        .rstN          (rstN),
        .opValid       (opValid),
        .opCode        (opCode),
        .targetMachine (targetMachine),
        .inFront       (inFront),
        .verifiedValid (verifiedValid),
        .verifiedOp    (verifiedOp),
        .dishCount     (dishCount)
    );

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkOp(input string name, input opCode_e got, input opCode_e want);
        if (got !== want) begin
            abortRun($sformatf("Fail at %0t: %s is %s, expected %s",
                               $time, name, got.name(), want.name()));
        end
    endtask

    task automatic checkCount(input string name, input logic [countWidth-1:0] got,
                              input logic [countWidth-1:0] want);
        if (got !== want) begin
            abortRun($sformatf("Fail at %0t: %s is %0d, expected %0d", $time, name, got, want));
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic want);
        if (got !== want) begin
            abortRun($sformatf("Fail at %0t: %s is %b, expected %b", $time, name, got, want));
        end
    endtask

    // five tables first, then mill and cutter, then two ovens
    function automatic int slotOfMachine(input int m);
        case (m)
            9:       return 0;
            11:      return 1;
            14:      return 2;
            17:      return 3;
            19:      return 4;
            7:       return 5;
            8:       return 6;
            12:      return 7;
            13:      return 8;
            default: return -1;
        endcase
    endfunction

    function automatic slotKind_e kindOfSlot(input int s);
        if (s < 5) return kindTable;
        if (s < 7) return kindProcessor;
        return kindOven;
    endfunction

    function automatic logic servable(input item_e it);
        return it == sweetMadame || it == chiliChicken || it == berryMissManjuu ||
               it == badDish;
    endfunction

    function automatic item_e processed(input item_e it);
        case (it)
            rawMeat:     return slicedMeat;
            wheat:       return flour;
            sweetFlower: return sugar;
            jueyunChili: return spice;
            slicedMeat:  return sausage;
            default:     return it;
        endcase
    endfunction

    function automatic int countIn(input int s, input item_e it);
        int hits;
        hits = 0;
        for (int i = 0; i < mCount[s]; i++) begin
            if (mItems[s][i] == it) hits++;
        end
        return hits;
    endfunction

    // matches oven contents in any order
    // itemNone when no recipe fits
    function automatic item_e cookResult(input int s);
        int n;
        n = mCount[s];
        if (n == 2 && countIn(s, rawMeat) == 1 && countIn(s, sweetFlower) == 1)
            return sweetMadame;
        if (n == 3 && countIn(s, spice) == 1 && countIn(s, rawMeat) == 1 &&
            countIn(s, jueyunChili) == 1)
            return chiliChicken;
        if (n == 3 && countIn(s, sugar) == 1 && countIn(s, berry) == 1 &&
            countIn(s, flour) == 1)
            return berryMissManjuu;
        if (n == 1 && servable(mItems[s][0]))
            return badDish;
        return itemNone;
    endfunction

    function automatic opCode_e slotStep(input opCode_e op, input int s);
        slotKind_e kind;
        logic      room;
        item_e     cooked;
        kind = kindOfSlot(s);
        if (op == opGet && mHand == itemNone && mCount[s] > 0) begin
            mCount[s] = mCount[s] - 1;
            mHand = mItems[s][mCount[s]];
            return opGet;
        end
        if (op == opPut || op == opThrow) begin
            if (kind == kindProcessor) room = (op == opPut) && mCount[s] == 0;
            else if (kind == kindOven) room = (op == opPut) && mCount[s] < stackDepth;
            else room = mCount[s] < stackDepth;
            if (mHand != itemNone && room) begin
                mItems[s][mCount[s]] = mHand;
                mCount[s] = mCount[s] + 1;
                mHand = itemNone;
                return op;
            end
        end
        if (op == opInteract) begin
            if (kind == kindProcessor && mCount[s] == 1) mItems[s][0] = processed(mItems[s][0]);
            cooked = cookResult(s);
            if (kind == kindOven && cooked != itemNone) begin
                mItems[s][0] = cooked;
                mCount[s] = 1;
            end
            return opInteract;
        end
        return opIgnore;
    endfunction

    function automatic opCode_e modelStep(input opCode_e op, input int m, input logic front);
        int s;
        s = slotOfMachine(m);
        if (!front) return opIgnore;
        if (m >= 1 && m <= 6) begin
            if (op == opGet && mHand == itemNone) begin
                mHand = item_e'(5'(m));
                return opGet;
            end
        end else if (s >= 0) begin
            return slotStep(op, s);
        end else if (m == 20) begin
            if ((op == opPut || op == opThrow) && mHand != itemNone) begin
                mHand = itemNone;
                return op;
            end
        end else if (m == 18 && op == opPut && servable(mHand)) begin
            mHand = itemNone;
            mDishes++;
            return opPut;
        end
        return opIgnore;
    endfunction

    task automatic issueOp(input opCode_e op, input int m, input logic front,
                           input logic [2:0] noise, input logic directed, input opCode_e want);
        opCode_e predicted;
        @(posedge clk);
        #1;
        opValid       = 1'b1;
        opCode        = op;
        targetMachine = {noise[2], 5'(m), noise[1:0]};
        inFront       = front;
        predicted     = modelStep(op, m, front);
        if (directed && predicted != want) begin
            abortRun($sformatf("directed step at machine %0d: rules give %s, sequence wants %s",
                               m, predicted.name(), want.name()));
        end
        expOps.push_back(predicted);
        expCounts.push_back(countWidth'(mDishes));
    endtask

    task automatic expectOp(input opCode_e op, input int m, input opCode_e want);
        issueOp(op, m, 1'b1, 3'b000, 1'b1, want);
    endtask

    task automatic idleCycle();
        @(posedge clk);
        #1;
        opValid = 1'b0;
        opCode  = opIgnore;
        inFront = 1'b0;
    endtask

    // machine numbers cover unmapped ones too; spare target bits are noise
    task automatic runRandom(input int numOps);
        int r;
        for (int i = 0; i < numOps; i++) begin
            r = $random(seed);
            if (r[2:0] == 3'd0) idleCycle();
            issueOp(opCode_e'(3'(r[10:3] % 8'd5)), int'(r[15:11]), r[17:16] != 2'b00,
                    r[20:18], 1'b0, opIgnore);
        end
    endtask

    always @(posedge clk) begin
        strobeSeen <= rstN && opValid;
        cycleCount = cycleCount + 1;
        if (cycleCount > maxCycles) begin
            abortRun($sformatf("timeout, run went past %0d cycles", maxCycles));
        end
    end

    // verdict of the strobe one cycle earlier
    always @(negedge clk) begin
        if (rstN) begin
            checkBit("verifiedValid", verifiedValid, strobeSeen);
            if (strobeSeen) begin
                checkOp("verifiedOp", verifiedOp, expOps.pop_front());
                checkCount("dishCount", dishCount, expCounts.pop_front());
            end else begin
                checkOp("verifiedOp", verifiedOp, opIgnore);
            end
        end
    end

    initial begin
        seed          = 81349;
        opValid       = 1'b0;
        opCode        = opIgnore;
        targetMachine = 8'h00;
        inFront       = 1'b0;
        mHand         = itemNone;
        mDishes       = 0;
        for (int s = 0; s < numModelSlots; s++) mCount[s] = 0;

        wait (rstN === 1'b1);
        @(negedge clk);
        checkBit("verifiedValid", verifiedValid, 1'b0);
        checkOp("verifiedOp", verifiedOp, opIgnore);
        checkCount("dishCount", dishCount, '0);

        issueOp(opGet, crateFirst, 1'b0, 3'b101, 1'b1, opIgnore);
        expectOp(opIgnore, crateFirst, opIgnore);

        // mill, then fill table 9 to capacity
        expectOp(opGet, 1, opGet);
        // hand is full but the player is not in front
        issueOp(opPut, trashBin, 1'b0, 3'b000, 1'b1, opIgnore);
        expectOp(opPut, stoneMill, opPut);
        expectOp(opInteract, stoneMill, opInteract);
        expectOp(opGet, stoneMill, opGet);
        expectOp(opPut, 9, opPut);
        expectOp(opGet, 2, opGet);
        expectOp(opPut, 9, opPut);
        expectOp(opGet, 3, opGet);
        expectOp(opPut, 9, opPut);
        expectOp(opGet, 5, opGet);
        expectOp(opPut, 9, opIgnore);
        expectOp(opThrow, trashBin, opThrow);
        idleCycle();

        // chili chicken in oven 12, then the customer
        expectOp(opGet, 4, opGet);
        expectOp(opPut, stoneMill, opPut);
        expectOp(opInteract, stoneMill, opInteract);
        expectOp(opGet, stoneMill, opGet);
        expectOp(opPut, ovenLow, opPut);
        expectOp(opGet, 1, opGet);
        expectOp(opPut, ovenLow, opPut);
        expectOp(opGet, 4, opGet);
        expectOp(opPut, ovenLow, opPut);
        expectOp(opInteract, ovenLow, opInteract);
        expectOp(opGet, ovenLow, opGet);
        expectOp(opPut, customer, opPut);
        expectOp(opGet, 6, opGet);
        expectOp(opPut, customer, opIgnore);
        expectOp(opThrow, trashBin, opThrow);
        idleCycle();

        // hand rules
        expectOp(opPut, 11, opIgnore);
        expectOp(opGet, 14, opIgnore);
        expectOp(opInteract, 14, opInteract);
        expectOp(opGet, 2, opGet);
        expectOp(opGet, 3, opIgnore);
        expectOp(opGet, 9, opIgnore);
        expectOp(opThrow, stoneMill, opIgnore);
        expectOp(opThrow, 11, opThrow);
        expectOp(opGet, 11, opGet);
        expectOp(opThrow, trashBin, opThrow);
        expectOp(opGet, 5, opGet);
        expectOp(opThrow, ovenHigh, opIgnore);
        expectOp(opThrow, trashBin, opThrow);

        // a recooked dish burns but can still be delivered
        expectOp(opGet, 1, opGet);
        expectOp(opPut, ovenHigh, opPut);
        expectOp(opGet, 3, opGet);
        expectOp(opPut, ovenHigh, opPut);
        expectOp(opInteract, ovenHigh, opInteract);
        expectOp(opInteract, ovenHigh, opInteract);
        expectOp(opGet, ovenHigh, opGet);
        expectOp(opPut, customer, opPut);
        idleCycle();

        runRandom(400);
        idleCycle();
        repeat (2) @(negedge clk);

        if (expOps.size() == 0 && dishCount == countWidth'(mDishes)) begin
            $display("TEST OK");
            $finish;
        end else begin
            abortRun("results still outstanding when the run ended");
        end
    end

endmodule

//--- dv/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
    parameter int periodNs    = 100,
    parameter int resetCycles = 10
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    // release just after an edge, like the rest of the stimulus
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #1;
        rstN = 1'b1;
    end

endmodule
